// File: test/dispatch_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// handshake and commit checks on the dispatch front end
module dispatch_asserts (
        input logic clk,
        input logic arst_n,
        input logic req,
        input logic ack,
        input logic commit,
        input dq_pkg::qidx_t tail,
        input dq_pkg::qcnt_t queued_cnt,
        input dq_pkg::slot_mask_t queued_onp,
        input dq_pkg::entry_mask_t iq_valid
);

        // read back by the testbench at the end of the run
        int fail_count = 0;

        // entries from tail up to tail plus c minus 1, wrapping modulo 8
        function automatic dq_pkg::entry_mask_t span(input dq_pkg::qidx_t t,
                                                     input dq_pkg::qcnt_t c);
                dq_pkg::entry_mask_t m;
                m = '0;
                for (int k = 0; k < int'(c); k++)
                        m[dq_pkg::qidx_t'(int'(t) + k)] = 1'b1;
                return m;
        endfunction

        // ====================
        // handshake
        // ====================

        // ack rises at the end of the commit cycle while req is still up
        ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
                $rose(ack) |-> $past(req))
                else begin
                        fail_count++;
                        $error("ack rose without req");
                end

        ack_falls_after_req: assert property (@(posedge clk) disable iff (!arst_n)
                $fell(ack) |-> !$past(req))
                else begin
                        fail_count++;
                        $error("ack fell while req was still high");
                end

        cnt_matches_mask: assert property (@(posedge clk) disable iff (!arst_n)
                ack |-> int'(queued_cnt) == $countones(queued_onp))
                else begin
                        fail_count++;
                        $error("queued_cnt does not match the bits of queued_onp");
                end

        // ====================
        // entry writes
        // ====================

        // a valid bit may only come up inside the range the last commit covered
        new_bits_in_range: assert property (@(posedge clk) disable iff (!arst_n)
                (iq_valid & ~$past(iq_valid) &
                 ~($past(commit) ? span($past(tail), queued_cnt) : '0)) == '0)
                else begin
                        fail_count++;
                        $error("valid bit set outside the committed range");
                end

endmodule

bind dispatch_top dispatch_asserts u_asserts (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .ack        (ack),
        .commit     (slot_bus.commit),
        .tail       (u_tail.tail),
        .queued_cnt (queued_cnt),
        .queued_onp (queued_onp),
        .iq_valid   (iq_valid)
);

`default_nettype wire

// File: test/dispatch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_tb;

        logic clk, arst_n, req, branch_miss, debug_on, release_en, ack;
        dq_pkg::slot_mask_t slot_vd, slot_jc, slot_ret, take_branch, queued_onp;
        dq_pkg::insn_t insn [dq_pkg::QSLOTS];
        dq_pkg::insn_t rd_insn;
        dq_pkg::qcnt_t queued_cnt;
        dq_pkg::qidx_t release_idx, rd_idx;
        dq_pkg::entry_mask_t iq_valid;

        // reference model of the queue state
        dq_pkg::qidx_t m_tail;
        dq_pkg::entry_mask_t m_valid;
        dq_pkg::insn_t m_words [dq_pkg::QENTRIES];

        // fields of one data file line
        dq_pkg::slot_mask_t f_vd, f_jc, f_ret, f_tb, f_onp;
        dq_pkg::insn_t f_i0, f_i1, f_i2, f_word;
        logic f_bm, f_dbg;
        dq_pkg::qcnt_t f_cnt;
        dq_pkg::qidx_t f_idx;
        dq_pkg::entry_mask_t f_valid;

        int errors, timeouts;
        bit timed_out;

        dispatch_top DUT (.*);

        always #20 clk = ~clk;

        task automatic compare(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
                if (got !== exp) begin
                        errors++;
                        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
                end
        endtask

        // the ack is sampled 2 ns after the edge, where it has settled
        task automatic wait_ack(input logic level);
                int n;
                n = 0;
                while (ack !== level && n < 50) begin
                        @(posedge clk);
                        #2;
                        n++;
                end
                if (ack !== level) begin
                        timeouts++;
                        timed_out = 1'b1;
                        $display("timeout while waiting for ack to become %0b", level);
                end
        endtask

        // ====================
        // reference model
        // ====================

        // walk the valid slots in order and stop at the first that cannot go
        function automatic void model_count(input dq_pkg::slot_mask_t vd, jc, ret, tb,
                                            input logic bm, dbg,
                                            output dq_pkg::qcnt_t cnt,
                                            output dq_pkg::slot_mask_t onp);
                int rank;
                logic going;
                dq_pkg::qidx_t e;
                rank = 0;
                onp = '0;
                going = vd inside {3'b001, 3'b010, 3'b100, 3'b011, 3'b110, 3'b111};
                for (int s = 0; s < dq_pkg::QSLOTS; s++) begin
                        if (vd[s] && going) begin
                                e = m_tail + dq_pkg::qidx_t'(rank);
                                if (m_valid[e] || (rank == 0 && bm) ||
                                    (rank > 0 && (dbg || rank >= dq_pkg::WAYS))) begin
                                        going = 1'b0;
                                end else begin
                                        onp[s] = 1'b1;
                                        rank++;
                                        // a flow change ends the group
                                        going = !(jc[s] || ret[s] || tb[s]);
                                end
                        end
                end
                cnt = dq_pkg::qcnt_t'(rank);
        endfunction

        // one full four-phase handshake, then the model follows the commit
        task automatic do_dispatch();
                dq_pkg::qcnt_t m_cnt;
                dq_pkg::slot_mask_t m_onp;
                int k;
                model_count(f_vd, f_jc, f_ret, f_tb, f_bm, f_dbg, m_cnt, m_onp);
                compare("model queued_cnt", m_cnt, f_cnt);
                compare("model queued_onp", m_onp, f_onp);
                slot_vd = f_vd;
                slot_jc = f_jc;
                slot_ret = f_ret;
                take_branch = f_tb;
                insn[0] = f_i0;
                insn[1] = f_i1;
                insn[2] = f_i2;
                branch_miss = f_bm;
                debug_on = f_dbg;
                req = 1'b1;
                wait_ack(1'b1);
                req = 1'b0;
                if (timed_out)
                        return;
                compare("queued_cnt", queued_cnt, f_cnt);
                compare("queued_onp", queued_onp, f_onp);
                wait_ack(1'b0);
                k = 0;
                for (int s = 0; s < dq_pkg::QSLOTS; s++) begin
                        if (m_onp[s]) begin
                                m_words[m_tail + dq_pkg::qidx_t'(k)] = insn[s];
                                m_valid[m_tail + dq_pkg::qidx_t'(k)] = 1'b1;
                                k++;
                        end
                end
                m_tail = m_tail + dq_pkg::qidx_t'(m_cnt);
                compare("iq_valid", iq_valid, m_valid);
        endtask

        task automatic release_entry();
                release_en = 1'b1;
                release_idx = f_idx;
                @(posedge clk);
                #2;
                release_en = 1'b0;
                m_valid[f_idx] = 1'b0;
                compare("iq_valid", iq_valid, m_valid);
        endtask

        // the read port is combinational, so it is checked on the falling edge
        task automatic read_entry();
                rd_idx = f_idx;
                @(negedge clk);
                compare("model word", m_words[f_idx], f_word);
                compare("model iq_valid", m_valid, f_valid);
                compare("rd_insn", rd_insn, f_word);
                compare("iq_valid", iq_valid, f_valid);
                @(posedge clk);
                #2;
        endtask

        // ====================
        // main sequence
        // ====================

        initial begin
                int fd;
                int n;
                string line;
                string op;
                clk = 1'b0;
                arst_n = 1'b0;
                {req, branch_miss, debug_on, release_en} = '0;
                {slot_vd, slot_jc, slot_ret, take_branch} = '0;
                insn[0] = '0;
                insn[1] = '0;
                insn[2] = '0;
                release_idx = '0;
                rd_idx = '0;
                errors = 0;
                timeouts = 0;
                timed_out = 1'b0;
                m_tail = '0;
                m_valid = '0;
                repeat (4) @(posedge clk);
                #2;
                arst_n = 1'b1;
                @(posedge clk);
                #2;
                fd = $fopen("test/dispatch_testdata.txt", "r");
                if (fd == 0) begin
                        errors++;
                        $display("could not open the test data file");
                end else begin
                        while (!timed_out && $fgets(line, fd) != 0) begin
                                op = "";
                                n = $sscanf(line, "%s", op);
                                if (op == "D") begin
                                        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h",
                                                    op, f_vd, f_jc, f_ret, f_tb, f_i0, f_i1,
                                                    f_i2, f_bm, f_dbg, f_cnt, f_onp);
                                        if (n != 12) begin
                                                errors++;
                                                $display("dispatch line with missing fields");
                                        end else begin
                                                do_dispatch();
                                        end
                                end else if (op == "R") begin
                                        n = $sscanf(line, "%s %h", op, f_idx);
                                        if (n != 2) begin
                                                errors++;
                                                $display("release line with missing fields");
                                        end else begin
                                                release_entry();
                                        end
                                end else if (op == "C") begin
                                        n = $sscanf(line, "%s %h %h %h", op, f_idx, f_word,
                                                    f_valid);
                                        if (n != 4) begin
                                                errors++;
                                                $display("read line with missing fields");
                                        end else begin
                                                read_entry();
                                        end
                                end
                        end
                        $fclose(fd);
                end
                $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                         errors, timeouts, DUT.u_asserts.fail_count);
                if (errors == 0 && timeouts == 0 && DUT.u_asserts.fail_count == 0)
                        $display("All tests passed");
                else
                        $display("Some tests failed");
                $finish;
        end

endmodule

`default_nettype wire

// File: test/dispatch_testdata.txt
# D vd jc ret tb insn0 insn1 insn2 branch_miss debug_on exp_cnt exp_onp, R idx
# C idx exp_word exp_iq_valid, every field in hex
D 1 0 0 0 a001 0000 0000 0 0 1 1
C 0 a001 01
R 0
D 2 0 0 0 0000 b002 0000 0 0 1 2
C 1 b002 02
R 1
D 4 0 0 0 0000 0000 c003 0 0 1 4
C 2 c003 04
R 2
D 7 0 4 0 d010 d011 d012 0 0 3 7
C 4 d011 38
D 7 1 0 0 e020 e021 e022 0 0 1 1
D 7 0 0 2 f030 f031 f032 0 0 2 3
C 0 f031 f9
D 7 0 0 0 1111 2222 3333 0 1 1 1
D 1 0 0 0 4444 0000 0000 1 0 0 0
D 5 0 0 0 5555 0000 6666 0 0 0 0
D 3 0 0 0 7777 8888 0000 0 1 1 1
C 2 7777 ff
D 1 0 0 0 9999 0000 0000 0 0 0 0
D 7 0 0 0 aaaa bbbb cccc 0 0 0 0
R 3
D 1 0 0 0 3333 0000 0000 0 0 1 1
C 3 3333 ff
D 1 0 0 0 4444 0000 0000 0 0 0 0

// File: verilog/dispatch_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// fetch side handshake for one dispatch
// the bundle is latched on req so the count cannot change under the handshake,
// commit pulses one cycle later and ack rises together with the held result
module dispatch_fsm (
        input logic clk,
        input logic arst_n,
        input logic req,
        input dq_pkg::slot_mask_t slot_vd,
        input dq_pkg::slot_mask_t slot_jc,
        input dq_pkg::slot_mask_t slot_ret,
        input dq_pkg::slot_mask_t take_branch,
        input dq_pkg::insn_t insn [dq_pkg::QSLOTS],
        input logic branch_miss,
        input logic debug_on,
        output logic ack,
        output dq_pkg::qcnt_t queued_cnt,
        output dq_pkg::slot_mask_t queued_onp,
        dispatch_if.fsm slot
);

        dq_pkg::disp_state_t state;

        // ====================
        // state and control
        // ====================

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state <= dq_pkg::IDLE;
                        ack <= 1'b0;
                        slot.commit <= 1'b0;
                        queued_cnt <= '0;
                        queued_onp <= '0;
                end else begin
                        case (state)
                        dq_pkg::IDLE: begin
                                if (req)
                                        state <= dq_pkg::EVAL;
                        end
                        dq_pkg::EVAL: begin
                                // the count has settled on the latched bundle
                                slot.commit <= 1'b1;
                                state <= dq_pkg::ACK;
                        end
                        dq_pkg::ACK: begin
                                if (slot.commit) begin
                                        // sample the result before the entries and tail move
                                        slot.commit <= 1'b0;
                                        ack <= 1'b1;
                                        queued_cnt <= slot.queued_cnt;
                                        queued_onp <= slot.queued_onp;
                                end else if (!req) begin
                                        state <= dq_pkg::DROP;
                                end
                        end
                        dq_pkg::DROP: begin
                                // ack falls first, IDLE follows one cycle later
                                if (ack)
                                        ack <= 1'b0;
                                else
                                        state <= dq_pkg::IDLE;
                        end
                        default: state <= dq_pkg::IDLE;
                        endcase
                end
        end

        // ====================
        // bundle latch
        // ====================

        always_ff @(posedge clk) begin
                if (state == dq_pkg::IDLE && req) begin
                        slot.slot_vd <= slot_vd;
                        slot.slot_jc <= slot_jc;
                        slot.slot_ret <= slot_ret;
                        slot.take_branch <= take_branch;
                        slot.insn <= insn;
                        slot.branch_miss <= branch_miss;
                        slot.debug_on <= debug_on;
                end
        end

endmodule

`default_nettype wire

// File: verilog/dispatch_if.sv
`timescale 1ns/1ps
`default_nettype none

// carries the latched fetch bundle from the FSM to the count logic and the entry
// array, the tail indices from the tail counter, and the count result back out
interface dispatch_if;

        // latched slot fields, one bit per slot
        dq_pkg::slot_mask_t slot_vd;
        dq_pkg::slot_mask_t slot_jc;
        dq_pkg::slot_mask_t slot_ret;
        dq_pkg::slot_mask_t take_branch;

        // latched instruction words, one per slot
        dq_pkg::insn_t insn [dq_pkg::QSLOTS];

        // mode bits captured along with the bundle
        logic branch_miss;
        logic debug_on;

        // entry targeted by the first, second and third valid slot
        dq_pkg::qidx_t tails [dq_pkg::QSLOTS];

        // result of the queueing decision
        dq_pkg::qcnt_t queued_cnt;
        dq_pkg::slot_mask_t queued_onp;

        // one-cycle strobe, entries are written and the tail moves at its end
        logic commit;

        // the FSM also samples the result so it can hold it while ack is high
        modport fsm (output slot_vd, slot_jc, slot_ret, take_branch, insn,
                     output branch_miss, debug_on, commit,
                     input queued_cnt, queued_onp);

        modport counter (output tails, input commit, queued_cnt);

        modport count (input slot_vd, slot_jc, slot_ret, take_branch,
                       input branch_miss, debug_on, tails,
                       output queued_cnt, queued_onp);

        modport array (input insn, tails, queued_onp, commit);

endinterface

`default_nettype wire

// File: verilog/dispatch_top.sv
`timescale 1ns/1ps
`default_nettype none

// dispatch front end of the instruction queue
// fetch offers up to three slots over a four-phase req/ack handshake,
// the issue side frees entries through the release strobe
module dispatch_top (
        input logic clk,
        input logic arst_n,
        input logic req,
        input logic branch_miss,
        input logic debug_on,
        input dq_pkg::slot_mask_t slot_vd,
        input dq_pkg::slot_mask_t slot_jc,
        input dq_pkg::slot_mask_t slot_ret,
        input dq_pkg::slot_mask_t take_branch,
        input dq_pkg::insn_t insn [dq_pkg::QSLOTS],
        output logic ack,
        output dq_pkg::qcnt_t queued_cnt,
        output dq_pkg::slot_mask_t queued_onp,
        input logic release_en,
        input dq_pkg::qidx_t release_idx,
        input dq_pkg::qidx_t rd_idx,
        output dq_pkg::insn_t rd_insn,
        output dq_pkg::entry_mask_t iq_valid
);

        // ====================
        // internal bus
        // ====================

        dispatch_if slot_bus ();

        // handshake, bundle latch and commit strobe
        dispatch_fsm u_fsm (
                .clk         (clk),
                .arst_n      (arst_n),
                .req         (req),
                .slot_vd     (slot_vd),
                .slot_jc     (slot_jc),
                .slot_ret    (slot_ret),
                .take_branch (take_branch),
                .insn        (insn),
                .branch_miss (branch_miss),
                .debug_on    (debug_on),
                .ack         (ack),
                .queued_cnt  (queued_cnt),
                .queued_onp  (queued_onp),
                .slot        (slot_bus.fsm)
        );

        // queueing decision on the latched bundle
        queue_count u_count (
                .slot (slot_bus.count),
                .iq_v (iq_valid)
        );

        tail_counter u_tail (
                .clk    (clk),
                .arst_n (arst_n),
                .slot   (slot_bus.counter)
        );

        // the occupancy vector feeds back into the count logic
        iq_entry_array u_array (
                .clk         (clk),
                .arst_n      (arst_n),
                .slot        (slot_bus.array),
                .release_en  (release_en),
                .release_idx (release_idx),
                .rd_idx      (rd_idx),
                .rd_insn     (rd_insn),
                .iq_v        (iq_valid)
        );

endmodule

`default_nettype wire

// File: verilog/dq_pkg.sv
`default_nettype none

// ====================
// dispatch queue sizes
// ====================

package dq_pkg;

        // number of instruction queue entries
        localparam int QENTRIES = 8;

        // fetch slots presented in one dispatch
        // the slot-pattern logic in queue_count is written for exactly three
        localparam int QSLOTS = 3;

        // most instructions that may enter the queue in one dispatch
        localparam int WAYS = 3;

        // ====================
        // vector types
        // ====================

        // index of one queue entry
        typedef logic [$clog2(QENTRIES)-1:0] qidx_t;

        // one bit per fetch slot, bit 0 is the oldest slot
        typedef logic [QSLOTS-1:0] slot_mask_t;

        // count of queued instructions, 0 to 3
        typedef logic [1:0] qcnt_t;

        // a compressed instruction word
        typedef logic [15:0] insn_t;

        // one valid bit per queue entry
        typedef logic [QENTRIES-1:0] entry_mask_t;

        // dispatch handshake states
        typedef enum logic [1:0] {
                IDLE,
                EVAL,
                ACK,
                DROP
        } disp_state_t;

endpackage

`default_nettype wire

// File: verilog/iq_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

// instruction queue storage, a valid bit and a word per entry
// commit fills entries from the tail, the issue side frees them by index
module iq_entry_array (
        input logic clk,
        input logic arst_n,
        dispatch_if.array slot,
        input logic release_en,
        input dq_pkg::qidx_t release_idx,
        input dq_pkg::qidx_t rd_idx,
        output dq_pkg::insn_t rd_insn,
        output dq_pkg::entry_mask_t iq_v
);

        dq_pkg::entry_mask_t valid;
        dq_pkg::insn_t words [dq_pkg::QENTRIES];

        // target entry of each slot, valid only where the slot queued
        dq_pkg::qidx_t slot_tgt [dq_pkg::QSLOTS];

        // queued slots take tail entries in slot order
        // a slot that did not queue does not use up an index
        always_comb begin
                dq_pkg::qcnt_t rank;
                rank = '0;
                for (int s = 0; s < dq_pkg::QSLOTS; s++) begin
                        slot_tgt[s] = slot.tails[rank];
                        if (slot.queued_onp[s])
                                rank = rank + 2'd1;
                end
        end

        // ====================
        // valid bits
        // ====================

        // release and commit never hit the same entry
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        valid <= '0;
                end else begin
                        if (release_en)
                                valid[release_idx] <= 1'b0;
                        if (slot.commit) begin
                                for (int s = 0; s < dq_pkg::QSLOTS; s++) begin
                                        if (slot.queued_onp[s])
                                                valid[slot_tgt[s]] <= 1'b1;
                                end
                        end
                end
        end

        // instruction words
        always_ff @(posedge clk) begin
                if (slot.commit) begin
                        for (int s = 0; s < dq_pkg::QSLOTS; s++) begin
                                if (slot.queued_onp[s])
                                        words[slot_tgt[s]] <= slot.insn[s];
                        end
                end
        end

        assign rd_insn = words[rd_idx];
        assign iq_v = valid;

endmodule

`default_nettype wire

// File: verilog/queue_count.sv
`timescale 1ns/1ps
`default_nettype none

// works out how many of the three fetch slots can enter the queue this
// dispatch and which of them do
// a slot needs its target entry to be free, and queueing stops after
// a slot that changes the flow of control
module queue_count (
        dispatch_if.count slot,
        input dq_pkg::entry_mask_t iq_v
);

        // free flag of the entry that the k-th valid slot would land in
        logic [dq_pkg::QSLOTS-1:0] tail_free;

        // slot ends the group: jump/call, return or taken branch
        dq_pkg::slot_mask_t flow;

        always_comb begin
                for (int k = 0; k < dq_pkg::QSLOTS; k++) begin
                        tail_free[k] = ~iq_v[slot.tails[k]];
                end
        end

        assign flow = slot.slot_jc | slot.slot_ret | slot.take_branch;

        // ====================
        // slot pattern decode
        // ====================

        always_comb begin
                slot.queued_cnt = '0;
                slot.queued_onp = '0;
                // a branch miss flushes the front end, nothing queues
                if (!slot.branch_miss) begin
                        case (slot.slot_vd)
                        3'b001, 3'b010, 3'b100: begin
                                // single slot, only its entry matters
                                if (tail_free[0]) begin
                                        slot.queued_cnt = 2'd1;
                                        slot.queued_onp = slot.slot_vd;
                                end
                        end
                        3'b011: begin
                                if (tail_free[0]) begin
                                        slot.queued_cnt = 2'd1;
                                        slot.queued_onp[0] = 1'b1;
                                        if (!flow[0] && tail_free[1] && !slot.debug_on &&
                                            dq_pkg::WAYS > 1) begin
                                                slot.queued_cnt = 2'd2;
                                                slot.queued_onp[1] = 1'b1;
                                        end
                                end
                        end
                        3'b110: begin
                                // slot 1 is the oldest here and takes the tail entry
                                if (tail_free[0]) begin
                                        slot.queued_cnt = 2'd1;
                                        slot.queued_onp[1] = 1'b1;
                                        if (!flow[1] && tail_free[1] && !slot.debug_on &&
                                            dq_pkg::WAYS > 1) begin
                                                slot.queued_cnt = 2'd2;
                                                slot.queued_onp[2] = 1'b1;
                                        end
                                end
                        end
                        3'b111: begin
                                if (tail_free[0]) begin
                                        slot.queued_cnt = 2'd1;
                                        slot.queued_onp[0] = 1'b1;
                                        if (!flow[0] && tail_free[1] && !slot.debug_on &&
                                            dq_pkg::WAYS > 1) begin
                                                slot.queued_cnt = 2'd2;
                                                slot.queued_onp[1] = 1'b1;
                                                // third slot only if the second did queue
                                                if (!flow[1] && tail_free[2] &&
                                                    dq_pkg::WAYS > 2) begin
                                                        slot.queued_cnt = 2'd3;
                                                        slot.queued_onp[2] = 1'b1;
                                                end
                                        end
                                end
                        end
                        // 000 has nothing to queue and 101 has a hole, both give zero
                        default: begin
                                slot.queued_cnt = '0;
                                slot.queued_onp = '0;
                        end
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: verilog/tail_counter.sv
`timescale 1ns/1ps
`default_nettype none

// queue tail pointer
// the entry after the last queued one is the next place to write
module tail_counter (
        input logic clk,
        input logic arst_n,
        dispatch_if.counter slot
);

        dq_pkg::qidx_t tail;

        // the index width matches the queue depth, so the sum wraps modulo 8
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        tail <= '0;
                end else if (slot.commit) begin
                        tail <= tail + dq_pkg::qidx_t'(slot.queued_cnt);
                end
        end

        // ====================
        // target indices
        // ====================

        // k-th valid slot targets tail plus k
        generate
                for (genvar k = 0; k < dq_pkg::QSLOTS; k++) begin : g_tails
                        assign slot.tails[k] = tail + dq_pkg::qidx_t'(k);
                end
        endgenerate

endmodule

`default_nettype wire

// File: vlog.f
verilog/dq_pkg.sv
verilog/dispatch_if.sv
verilog/queue_count.sv
verilog/dispatch_fsm.sv
verilog/tail_counter.sv
verilog/iq_entry_array.sv
verilog/dispatch_top.sv
test/dispatch_asserts.sv
test/dispatch_tb.sv
